// File: logic/cameraPkg.sv
`default_nettype none

package cameraPkg;

  // per-line byte count, also used for the line count
  localparam int byteCountBits = 11;

  localparam int frameCountBits = 8;  // wraps at 256

  localparam int grayBits = 8;

  localparam int pixelsPerWord = 4;

  // camera bytes arrive high byte first
  typedef struct packed {
    logic [7:0] high;
    logic [7:0] low;
  } pixelBytes;

  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } pixelColor;

  // collected as raw bytes, read back as color fields
  typedef union packed {
    pixelBytes raw;
    pixelColor color;
  } rgb565Pixel;

endpackage

`default_nettype wire

// File: logic/ciPkg.sv
`default_nettype none

package ciPkg;

  localparam int ciWordBits = 32;
  localparam int ciIdBits = 8;
  localparam int ciCodeBits = 4;  // low bits of ciValueA

  localparam logic [ciCodeBits-1:0] readBytesPerLine = 4'd0;
  localparam logic [ciCodeBits-1:0] readLinesPerFrame = 4'd1;
  localparam logic [ciCodeBits-1:0] readFrameCount = 4'd2;
  localparam logic [ciCodeBits-1:0] writeGrabEnable = 4'd6;
  localparam logic [ciCodeBits-1:0] readLineWord = 4'd7;

endpackage

`default_nettype wire

// File: logic/lineTimingIf.sv
`timescale 1ns/1ps
`default_nettype none

interface lineTimingIf import cameraPkg::*; ();

  logic [byteCountBits-1:0] bytesPerLine;   // latched at hsync fall
  logic [byteCountBits-1:0] linesPerFrame;  // latched at vsync fall
  logic [frameCountBits-1:0] frameCount;
  logic lineEnd;                             // one-cycle pulse

  modport source (
    output bytesPerLine,
    output linesPerFrame,
    output frameCount,
    output lineEnd
  );

  modport sink (
    input bytesPerLine,
    input linesPerFrame,
    input frameCount,
    input lineEnd
  );

endinterface

`default_nettype wire

// File: logic/syncTiming.sv
`timescale 1ns/1ps
`default_nettype none

module syncTiming import cameraPkg::*; (
  input logic pclk,
  input logic rst,
  input logic hsync,
  input logic vsync,
  lineTimingIf.source timing
);

  logic hsyncReg;
  logic vsyncReg;
  logic hsyncFall;
  logic vsyncFall;
  logic lineEndReg;
  logic [byteCountBits-1:0] byteCount;
  logic [byteCountBits-1:0] lineCount;
  logic [byteCountBits-1:0] lineTotal;
  logic [byteCountBits-1:0] bytesLatched;
  logic [byteCountBits-1:0] linesLatched;
  logic [frameCountBits-1:0] frameCounter;

  assign hsyncFall = hsyncReg & ~hsync;  // previous sample high, this one low
  assign vsyncFall = vsyncReg & ~vsync;

  // a line ending on the same edge as the frame still counts
  assign lineTotal = lineCount + byteCountBits'(hsyncFall);

  always_ff @(posedge pclk) begin
    if (rst) begin
      hsyncReg <= 1'b0;
      vsyncReg <= 1'b0;
      lineEndReg <= 1'b0;
      byteCount <= '0;
      lineCount <= '0;
      bytesLatched <= '0;
      linesLatched <= '0;
      frameCounter <= '0;
    end else begin
      hsyncReg <= hsync;
      vsyncReg <= vsync;
      lineEndReg <= hsyncFall;

      if (hsyncFall) begin
        bytesLatched <= byteCount;
        byteCount <= '0;
      end else if (hsync) begin
        byteCount <= byteCount + 1'b1;  // one byte per edge with hsync high
      end

      if (vsyncFall) begin
        linesLatched <= lineTotal;
        lineCount <= '0;
        frameCounter <= frameCounter + 1'b1;
      end else if (hsyncFall) begin
        lineCount <= lineCount + 1'b1;
      end
    end
  end

  assign timing.lineEnd = lineEndReg;
  assign timing.bytesPerLine = bytesLatched;
  assign timing.linesPerFrame = linesLatched;
  assign timing.frameCount = frameCounter;

endmodule

`default_nettype wire

// File: logic/grayPacker.sv
`timescale 1ns/1ps
`default_nettype none

module grayPacker import cameraPkg::*; #(
  parameter int lineWords = 160,
  localparam int addrBits = $clog2(lineWords),
  localparam int wordBits = grayBits * pixelsPerWord
) (
  input logic pclk,
  input logic rst,
  input logic hsync,
  input logic grabEnable,
  input logic [7:0] camData,
  lineTimingIf.sink timing,
  output logic writeEnable,
  output logic [addrBits-1:0] writeAddress,
  output logic [wordBits-1:0] writeWord
);

  localparam int groupBytes = 2 * pixelsPerWord;

  logic [$clog2(groupBytes)-1:0] bytePos;
  logic [7:0] heldBytes [groupBytes-1];
  logic [7:0] groupData [groupBytes];
  rgb565Pixel pixels [pixelsPerWord];
  logic lineEnable;
  logic [addrBits:0] wordCount;  // one extra bit so it can reach lineWords
  logic lastByte;
  logic wordInRange;

  function automatic logic [grayBits-1:0] toGray(input rgb565Pixel pixel);
    logic [7:0] red8;
    logic [7:0] green8;
    logic [7:0] blue8;
    logic [15:0] weighted;
    red8 = {pixel.color.red, pixel.color.red[4:2]};
    green8 = {pixel.color.green, pixel.color.green[5:4]};
    blue8 = {pixel.color.blue, pixel.color.blue[4:2]};
    weighted = 16'd77 * red8 + 16'd150 * green8 + 16'd29 * blue8;  // weights sum to 256
    return weighted[15:8];
  endfunction

  assign lastByte = hsync && (bytePos == '1);
  assign wordInRange = wordCount < lineWords;
  assign writeEnable = lastByte && lineEnable && wordInRange;
  assign writeAddress = wordCount[addrBits-1:0];

  // incoming byte completes the group, no extra register stage
  always_comb begin
    for (int i = 0; i < groupBytes - 1; i++) begin
      groupData[i] = heldBytes[i];
    end
    groupData[groupBytes-1] = camData;
    for (int p = 0; p < pixelsPerWord; p++) begin
      pixels[p].raw.high = groupData[2*p];
      pixels[p].raw.low = groupData[2*p+1];
      writeWord[(pixelsPerWord-1-p)*grayBits +: grayBits] = toGray(pixels[p]);  // first pixel in msb
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      bytePos <= '0;
      wordCount <= '0;
      lineEnable <= 1'b0;
    end else if (timing.lineEnd) begin
      bytePos <= '0;
      wordCount <= '0;
      lineEnable <= grabEnable;  // takes effect for the next whole line
    end else if (hsync) begin
      bytePos <= bytePos + 1'b1;
      if (lastByte && wordInRange) begin
        wordCount <= wordCount + 1'b1;
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (hsync && !lastByte) begin
      heldBytes[bytePos] <= camData;
    end
  end

endmodule

`default_nettype wire

// File: logic/lineBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module lineBuffer import cameraPkg::*; #(
  parameter int lineWords = 160,
  localparam int addrBits = $clog2(lineWords),
  localparam int wordBits = grayBits * pixelsPerWord
) (
  input logic pclk,
  input logic writeEnable,
  input logic [addrBits-1:0] writeAddress,
  input logic [wordBits-1:0] writeWord,
  input logic [addrBits-1:0] readAddress,
  output logic [wordBits-1:0] readWord
);

  logic [wordBits-1:0] memory [lineWords];

  always_ff @(posedge pclk) begin
    if (writeEnable) begin
      memory[writeAddress] <= writeWord;
    end
    readWord <= memory[readAddress];  // same-address collision returns the old word
  end

endmodule

`default_nettype wire

// File: logic/ciResponder.sv
`timescale 1ns/1ps
`default_nettype none

module ciResponder import ciPkg::*; #(
  parameter logic [ciIdBits-1:0] customInstructionId = '0,
  parameter int lineWords = 160,
  localparam int addrBits = $clog2(lineWords)
) (
  input logic pclk,
  input logic rst,
  input logic ciStart,
  input logic ciCke,
  input logic [ciIdBits-1:0] ciN,
  input logic [ciWordBits-1:0] ciValueA,
  input logic [ciWordBits-1:0] ciValueB,
  input logic [ciWordBits-1:0] readWord,
  lineTimingIf.sink timing,
  output logic [addrBits-1:0] readAddress,
  output logic grabEnable,
  output logic [ciWordBits-1:0] ciResult,
  output logic ciDone
);

  logic accept;
  logic [ciCodeBits-1:0] command;
  logic [ciCodeBits-1:0] commandReg;
  logic doneReg;
  logic [ciWordBits-1:0] selected;

  assign accept = ciStart && ciCke && (ciN == customInstructionId);
  assign command = ciValueA[ciCodeBits-1:0];

  // buffer read starts with the instruction, data lands in the done cycle
  assign readAddress = ciValueB[addrBits-1:0];

  assign ciDone = doneReg;
  assign ciResult = doneReg ? selected : '0;

  always_ff @(posedge pclk) begin
    if (rst) begin
      doneReg <= 1'b0;
      grabEnable <= 1'b0;
    end else begin
      doneReg <= accept;
      if (accept && command == writeGrabEnable) begin
        grabEnable <= ciValueB[0];
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (accept) begin
      commandReg <= command;
    end
  end

  always_comb begin
    case (commandReg)
      readBytesPerLine: selected = ciWordBits'(timing.bytesPerLine);
      readLinesPerFrame: selected = ciWordBits'(timing.linesPerFrame);
      readFrameCount: selected = ciWordBits'(timing.frameCount);
      readLineWord: selected = readWord;
      default: selected = '0;  // includes the grab enable write
    endcase
  end

endmodule

`default_nettype wire

// File: logic/cameraGrabber.sv
`timescale 1ns/1ps
`default_nettype none

module cameraGrabber import cameraPkg::*, ciPkg::*; #(
  parameter logic [ciIdBits-1:0] customInstructionId = '0,
  parameter int lineWords = 160
) (
  input logic pclk,
  input logic rst,
  input logic hsync,
  input logic vsync,
  input logic [7:0] camData,
  input logic ciStart,
  input logic ciCke,
  input logic [ciIdBits-1:0] ciN,
  input logic [ciWordBits-1:0] ciValueA,
  input logic [ciWordBits-1:0] ciValueB,
  output logic [ciWordBits-1:0] ciResult,
  output logic ciDone
);

  localparam int addrBits = $clog2(lineWords);
  localparam int wordBits = grayBits * pixelsPerWord;

  logic writeEnable;
  logic [addrBits-1:0] writeAddress;
  logic [wordBits-1:0] writeWord;
  logic [addrBits-1:0] readAddress;
  logic [wordBits-1:0] readWord;
  logic grabEnable;

  lineTimingIf timing ();

  syncTiming syncTiming (
    .pclk(pclk),
    .rst(rst),
    .hsync(hsync),
    .vsync(vsync),
    .timing(timing.source)
  );

  grayPacker #(
    .lineWords(lineWords)
  ) grayPacker (
    .pclk(pclk),
    .rst(rst),
    .hsync(hsync),
    .grabEnable(grabEnable),
    .camData(camData),
    .timing(timing.sink),
    .writeEnable(writeEnable),
    .writeAddress(writeAddress),
    .writeWord(writeWord)
  );

  lineBuffer #(
    .lineWords(lineWords)
  ) lineBuffer (
    .pclk(pclk),
    .writeEnable(writeEnable),
    .writeAddress(writeAddress),
    .writeWord(writeWord),
    .readAddress(readAddress),
    .readWord(readWord)
  );

  ciResponder #(
    .customInstructionId(customInstructionId),
    .lineWords(lineWords)
  ) ciResponder (
    .pclk(pclk),
    .rst(rst),
    .ciStart(ciStart),
    .ciCke(ciCke),
    .ciN(ciN),
    .ciValueA(ciValueA),
    .ciValueB(ciValueB),
    .readWord(readWord),
    .timing(timing.sink),
    .readAddress(readAddress),
    .grabEnable(grabEnable),
    .ciResult(ciResult),
    .ciDone(ciDone)
  );

endmodule

`default_nettype wire

// File: testbench/cameraGrabberTb.sv
`timescale 1ns/1ps
`default_nettype none

module cameraGrabberTb import ciPkg::*; ();

  localparam int lineWords = 160;
  localparam logic [ciIdBits-1:0] ciId = 8'd9;
  localparam int lineGap = 6;
  localparam int frameGap = 10;
  localparam int frameBytes = 400;
  localparam int timeoutCycles = 20000;  // about twice the cycles of all tests

  logic pclk;
  logic rst;
  logic hsync;
  logic vsync;
  logic [7:0] camData;
  logic ciStart;
  logic ciCke;
  logic [ciIdBits-1:0] ciN;
  logic [ciWordBits-1:0] ciValueA;
  logic [ciWordBits-1:0] ciValueB;
  logic [ciWordBits-1:0] ciResult;
  logic ciDone;

  integer seed = 12377;
  int cycleCount = 0;
  logic grabModel = 1'b0;        // last value written with code 6
  logic lineEnableModel = 1'b0;  // latched at each line end
  logic [7:0] frameModel = 8'd0;  // frames ended with vsync
  logic [31:0] modelWords [lineWords];
  logic [31:0] savedWords [lineWords];

  cameraGrabber #(
    .customInstructionId(ciId),
    .lineWords(lineWords)
  ) dut (
    .pclk(pclk),
    .rst(rst),
    .hsync(hsync),
    .vsync(vsync),
    .camData(camData),
    .ciStart(ciStart),
    .ciCke(ciCke),
    .ciN(ciN),
    .ciValueA(ciValueA),
    .ciValueB(ciValueB),
    .ciResult(ciResult),
    .ciDone(ciDone)
  );

  always #5 pclk = ~pclk;

  task automatic abortRun();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  always @(posedge pclk) begin
    cycleCount++;
    assert (cycleCount < timeoutCycles) else begin
      $display("timeout after %0d cycles, tests did not finish", cycleCount);
      abortRun();
    end
  end

  // RGB565 to 8-bit gray with weights 77/150/29 over 256
  function automatic logic [7:0] grayOf(input logic [7:0] highByte, input logic [7:0] lowByte);
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
    int sum;
    red = highByte[7:3];
    green = {highByte[2:0], lowByte[7:5]};
    blue = lowByte[4:0];
    sum = 77 * int'({red, red[4:2]}) + 150 * int'({green, green[5:4]})
      + 29 * int'({blue, blue[4:2]});
    return 8'(sum / 256);
  endfunction

  // first byte of the group in bits 63:56
  function automatic logic [31:0] modelWord(input logic [63:0] group);
    return {grayOf(group[63:56], group[55:48]), grayOf(group[47:40], group[39:32]),
      grayOf(group[31:24], group[23:16]), grayOf(group[15:8], group[7:0])};
  endfunction

  task automatic waitCycles(input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge pclk);
      #1;
    end
  endtask

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    assert (got === expected) else begin
      $display("mismatch %s: got %h expected %h", name, got, expected);
      abortRun();
    end
  endtask

  task automatic expectIdle(input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge pclk);
      #1;
      assert (ciDone === 1'b0 && ciResult === '0) else begin
        $display("ciDone or ciResult active without an accepted start");
        abortRun();
      end
    end
  endtask

  // back-to-back calls keep ciStart high
  task automatic ciCall(input logic [ciIdBits-1:0] id, input logic [3:0] code,
                        input logic [31:0] operand, output logic [31:0] result);
    ciStart = 1'b1;
    ciCke = 1'b1;
    ciN = id;
    ciValueA = 32'(code);
    ciValueB = operand;
    @(posedge pclk);
    #1;
    ciStart = 1'b0;
    ciCke = 1'b0;
    assert (ciDone === 1'b1) else begin
      $display("ciDone did not pulse one cycle after the start of code %0d", code);
      abortRun();
    end
    result = ciResult;
  endtask

  task automatic expectResult(input logic [3:0] code, input logic [31:0] operand,
                              input string name, input logic [31:0] expected);
    logic [31:0] result;
    ciCall(ciId, code, operand, result);
    compareValue(name, result, expected);
  endtask

  task automatic sendLine(input int byteCount);
    logic [7:0] lineData [$];
    logic [7:0] value;
    logic [63:0] group;
    for (int i = 0; i < byteCount; i++) begin
      value = 8'($random(seed));
      lineData.push_back(value);
      hsync = 1'b1;
      camData = value;
      @(posedge pclk);
      #1;
    end
    hsync = 1'b0;
    camData = 8'h00;
    waitCycles(lineGap);
    if (lineEnableModel) begin
      for (int w = 0; w < byteCount / 8 && w < lineWords; w++) begin
        for (int k = 0; k < 8; k++) begin
          group = {group[55:0], lineData[8*w+k]};
        end
        modelWords[w] = modelWord(group);  // leftover bytes dropped
      end
    end
    lineEnableModel = grabModel;
  endtask

  task automatic sendFrame(input int lines, input int byteCount);
    vsync = 1'b1;
    waitCycles(frameGap);
    for (int l = 0; l < lines; l++) begin
      sendLine(byteCount);
    end
    vsync = 1'b0;
    frameModel = frameModel + 8'd1;
    waitCycles(frameGap);
  endtask

  task automatic checkResetState();
    expectIdle(4);
    expectResult(readBytesPerLine, 0, "bytesPerLine", 0);
    expectResult(readLinesPerFrame, 0, "linesPerFrame", 0);
    expectResult(readFrameCount, 0, "frameCount", 0);
    expectIdle(3);
    ciStart = 1'b1;  // wrong instruction number
    ciCke = 1'b1;
    ciN = ciId + 8'd1;
    ciValueA = 32'(readFrameCount);
    @(posedge pclk);
    #1;
    ciStart = 1'b0;
    ciCke = 1'b0;
    assert (ciDone === 1'b0) else begin
      $display("ciDone pulsed for a start with a foreign instruction number");
      abortRun();
    end
    expectIdle(3);
  endtask

  task automatic measureLines();
    sendLine(48);
    expectResult(readBytesPerLine, 0, "bytesPerLine", 48);
    sendLine(24);
    expectResult(readBytesPerLine, 0, "bytesPerLine", 24);
  endtask

  task automatic measureFrames();
    sendFrame(0, 0);  // frame boundary that clears the lines of the earlier tests
    expectResult(readFrameCount, 0, "frameCount", 32'(frameModel));
    sendFrame(5, frameBytes);
    expectResult(readLinesPerFrame, 0, "linesPerFrame", 5);
    expectResult(readFrameCount, 0, "frameCount", 32'(frameModel));
    expectResult(readBytesPerLine, 0, "bytesPerLine", frameBytes);
    repeat (3) sendFrame(5, frameBytes);
    expectResult(readFrameCount, 0, "frameCount", 32'(frameModel));
    expectResult(readLinesPerFrame, 0, "linesPerFrame", 5);
  endtask

  task automatic packGrayLine();
    expectResult(writeGrabEnable, 1, "grab enable write", 0);
    grabModel = 1'b1;
    sendLine(16);  // only latches the enable
    sendLine(64);
    for (int w = 0; w < 8; w++) begin
      expectResult(readLineWord, w, $sformatf("line word %0d", w), modelWords[w]);
    end
    expectResult(readLineWord, 6, "line word 6", modelWords[6]);
    expectResult(readLineWord, 1, "line word 1", modelWords[1]);
    expectIdle(2);
    for (int w = 0; w < lineWords; w++) begin
      savedWords[w] = modelWords[w];
    end
  endtask

  task automatic holdWhenDisabled();
    expectResult(writeGrabEnable, 0, "grab enable write", 0);
    grabModel = 1'b0;
    sendLine(6);  // still enabled but too short for a word
    sendLine(64);
    sendLine(64);
    for (int w = 0; w < 8; w++) begin
      expectResult(readLineWord, w, $sformatf("line word %0d", w), savedWords[w]);
    end
  endtask

  task automatic readUnusedCodes();
    expectResult(4'd3, 32'hffff_ffff, "code 3 result", 0);
    expectResult(4'd15, 32'h0000_0001, "code 15 result", 0);
    expectIdle(2);
  endtask

  initial begin
    pclk = 1'b0;
    rst = 1'b1;
    hsync = 1'b0;
    vsync = 1'b0;
    camData = 8'h00;
    ciStart = 1'b0;
    ciCke = 1'b0;
    ciN = '0;
    ciValueA = '0;
    ciValueB = '0;
    repeat (3) @(posedge pclk);
    #1;
    rst = 1'b0;
    checkResetState();
    measureLines();
    measureFrames();
    packGrayLine();
    holdWhenDisabled();
    readUnusedCodes();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
logic/cameraPkg.sv
logic/ciPkg.sv
logic/lineTimingIf.sv
logic/syncTiming.sv
logic/grayPacker.sv
logic/lineBuffer.sv
logic/ciResponder.sv
logic/cameraGrabber.sv
testbench/cameraGrabberTb.sv

// File: Makefile
VERILATOR ?= verilator
BUILD_FLAGS = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP = cameraGrabberTb
FILELIST = compile.f
OBJ_DIR = obj_dir

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

.PHONY: all build run lint clean
